/* Makefile */
# verilator build of the packet generator testbench
TOP := tb_pkt_gen

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

/* hw/frame_builder.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// builds header and payload words and drives the stream registers
// outputs follow the FSM state by one tx_ready cycle
//--------------------------------------------------------------------------
module frame_builder (
   input  logic                reset,           // clock
   input  logic                clk,             // async reset
   input  pkt_gen_pkg::state_t state,
   input  logic                tx_ready,
   input  logic                random_payload,
   input  logic [47:0]         mac_sa,
   input  logic [47:0]         mac_da,
   input  pkt_gen_pkg::len_t   length,
   input  logic [15:0]         seq_num,
   input  logic                last_word,
   input  pkt_gen_pkg::beat_t  prbs,
   output pkt_gen_pkg::beat_t  tx_data,
   output logic                tx_valid,
   output logic                tx_sop,
   output logic                tx_eop,
   output pkt_gen_pkg::empty_t tx_empty
);
   import pkt_gen_pkg::*;

   beat_t incr_pat;     // incrementing payload word
   beat_t incr_nxt;
   beat_t word_sel;     // word for the current state

   // each byte steps on its own, wrapping at 256
   always_comb begin
      for (int b = 0; b < 8; b++) begin
         incr_nxt[b*8 +: 8] = incr_pat[b*8 +: 8] + incr_step;
      end
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk)                  incr_pat <= incr_first;
      else if (state != st_data) incr_pat <= incr_first;   // restart per packet
      else if (tx_ready)        incr_pat <= incr_nxt;
   end

   always_comb begin
      case (state)
         st_dest_src:    word_sel = {mac_da, mac_sa[47:32]};
         st_src_len_seq: word_sel = {mac_sa[31:0], length, seq_num};
         default:        word_sel = random_payload ? prbs : incr_pat;
      endcase
   end

   //-----------------------------------------------------------------------
   // stream registers, all hold while tx_ready is low
   //-----------------------------------------------------------------------
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         tx_data  <= '0;
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else if (tx_ready) begin
         tx_data  <= word_sel;
         tx_valid <= state inside {st_dest_src, st_src_len_seq, st_data};
         tx_sop   <= (state == st_dest_src);
         tx_eop   <= last_word;                    // only high in word 1 or data
         tx_empty <= (state == st_data && last_word) ? 3'd0 - length[2:0] : 3'd0;
      end
   end

   a_empty_on_eop: assert property (@(posedge reset) disable iff (clk)
      tx_empty != '0 |-> tx_valid && tx_eop);

endmodule

/* hw/pkt_csr.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// register bank of the packet generator
// decodes bus writes, returns reads one cycle late, pulses start
//--------------------------------------------------------------------------
module pkt_csr (
   input  logic                           reset,        // clock
   input  logic                           clk,          // async reset, active high
   input  pkt_gen_pkg::addr_t             address,
   input  logic                           write,
   input  logic                           read,
   input  pkt_gen_pkg::word_t             writedata,
   output pkt_gen_pkg::word_t             readdata,
   output logic                           waitrequest,
   input  pkt_gen_pkg::word_t             tx_pkt_cnt,
   output logic                           start,
   output logic                           stop,
   output pkt_gen_pkg::word_t             num_pkts,
   output logic                           random_payload,
   output pkt_gen_pkg::len_t              pkt_length,
   output logic [47:0]                    mac_sa,
   output logic [47:0]                    mac_da,
   output logic [pkt_gen_pkg::seed_w-1:0] seed
);
   import pkt_gen_pkg::*;

   word_t                mac_sa0;
   logic [15:0]          mac_sa1;
   word_t                mac_da0;
   logic [15:0]          mac_da1;
   word_t                seed0;
   word_t                seed1;
   logic [seed_hi_w-1:0] seed2;
   logic                 start_reg;   // self-clearing start bit
   logic                 start_d;     // for edge detection
   logic                 wr_d;
   logic                 rd_d;

   //-----------------------------------------------------------------------
   // configuration registers
   //-----------------------------------------------------------------------
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         num_pkts       <= '0;
         random_payload <= 1'b0;
         stop           <= 1'b0;
         mac_sa0        <= '0;
         mac_sa1        <= '0;
         mac_da0        <= '0;
         mac_da1        <= '0;
         seed0          <= seed0_rst;
         seed1          <= seed1_rst;
         seed2          <= seed2_rst;
         pkt_length     <= '0;
      end else if (write) begin
         case (address)
            addr_num_pkts:       num_pkts       <= writedata;
            addr_random_payload: random_payload <= writedata[0];
            addr_stop:           stop           <= writedata[0];   // level, seen between packets
            addr_mac_sa0:        mac_sa0        <= writedata;
            addr_mac_sa1:        mac_sa1        <= writedata[15:0];
            addr_mac_da0:        mac_da0        <= writedata;
            addr_mac_da1:        mac_da1        <= writedata[15:0];
            addr_rnd_seed0:      seed0          <= writedata;
            addr_rnd_seed1:      seed1          <= writedata;
            addr_rnd_seed2:      seed2          <= writedata[seed_hi_w-1:0];
            addr_pkt_length:     pkt_length     <= writedata[15:0];
            default: ;
         endcase
      end
   end

   assign mac_sa = {mac_sa1, mac_sa0};
   assign mac_da = {mac_da1, mac_da0};
   assign seed   = {seed2, seed1, seed0};   // 5 + 32 + 32 bits

   // start bit sets on the write and drops on the next edge
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         start_reg <= 1'b0;
         start_d   <= 1'b0;
      end else begin
         start_reg <= write && (address == addr_start) && writedata[0];
         start_d   <= start_reg;
      end
   end

   assign start = start_reg & ~start_d;   // one pulse even if write is held

   // waitrequest on the first cycle of each access
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         wr_d <= 1'b0;
         rd_d <= 1'b0;
      end else begin
         wr_d <= write;
         rd_d <= read;
      end
   end

   assign waitrequest = (write & ~wr_d) | (read & ~rd_d);

   //-----------------------------------------------------------------------
   // read mux, one cycle latency
   //-----------------------------------------------------------------------
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            addr_num_pkts:       readdata <= num_pkts;
            addr_random_payload: readdata <= word_t'(random_payload);
            addr_start:          readdata <= word_t'(start_reg);
            addr_stop:           readdata <= word_t'(stop);
            addr_mac_sa0:        readdata <= mac_sa0;
            addr_mac_sa1:        readdata <= word_t'(mac_sa1);
            addr_mac_da0:        readdata <= mac_da0;
            addr_mac_da1:        readdata <= word_t'(mac_da1);
            addr_tx_pkt_cnt:     readdata <= tx_pkt_cnt;
            addr_rnd_seed0:      readdata <= seed0;
            addr_rnd_seed1:      readdata <= seed1;
            addr_rnd_seed2:      readdata <= word_t'(seed2);
            addr_pkt_length:     readdata <= word_t'(pkt_length);
            default:             readdata <= '0;   // unmapped
         endcase
      end
   end

   // the FSM sees exactly one start per write, however long write stays high
   a_start_pulse: assert property (@(posedge reset) disable iff (clk)
      start |=> !start);

endmodule

/* hw/pkt_gen_fsm.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// packet sequencing FSM, one state per stream word
// advances with tx_ready except for the single transition cycle
//--------------------------------------------------------------------------
module pkt_gen_fsm (
   input  logic                reset,      // clock
   input  logic                clk,        // async reset
   input  logic                start,
   input  logic                stop,
   input  logic                tx_ready,
   input  logic                last_word,  // from the length counter
   input  logic                pkts_done,
   output pkt_gen_pkg::state_t state
);
   import pkt_gen_pkg::*;

   state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (start) state_nxt = st_dest_src;
         end
         st_dest_src: begin
            if (tx_ready) state_nxt = st_src_len_seq;
         end
         st_src_len_seq: begin
            // zero length packets end on word 1
            if (tx_ready) state_nxt = last_word ? st_transition : st_data;
         end
         st_data: begin
            if (tx_ready && last_word) state_nxt = st_transition;
         end
         st_transition: begin
            // stop only takes effect here, between packets
            state_nxt = (stop || pkts_done) ? st_idle : st_dest_src;
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk) state <= st_idle;
      else     state <= state_nxt;
   end

   a_state_legal: assert property (@(posedge reset) disable iff (clk)
      state inside {st_idle, st_dest_src, st_src_len_seq, st_data, st_transition});

endmodule

/* hw/pkt_gen_pkg.sv */
//--------------------------------------------------------------------------
// shared types, register map and constants of the packet generator
// imported by the RTL modules and by the testbench
//--------------------------------------------------------------------------
package pkt_gen_pkg;

   typedef logic [7:0]  addr_t;   // register bus address
   typedef logic [31:0] word_t;   // register bus data
   typedef logic [63:0] beat_t;   // one stream word
   typedef logic [2:0]  empty_t;  // empty bytes in the eop word
   typedef logic [15:0] len_t;    // payload length, byte count

   typedef enum logic [2:0] {
      st_idle        = 3'd0,
      st_dest_src    = 3'd1,    // word 0, sop
      st_src_len_seq = 3'd2,    // word 1
      st_data        = 3'd3,    // payload words
      st_transition  = 3'd4     // single gap cycle between packets
   } state_t;

   //-----------------------------------------------------------------------
   // register map
   //-----------------------------------------------------------------------
   localparam addr_t addr_num_pkts       = 8'h00;
   localparam addr_t addr_random_payload = 8'h02;
   localparam addr_t addr_start          = 8'h03;
   localparam addr_t addr_stop           = 8'h04;
   localparam addr_t addr_mac_sa0        = 8'h05;  // sa 31:0
   localparam addr_t addr_mac_sa1        = 8'h06;  // sa 47:32
   localparam addr_t addr_mac_da0        = 8'h07;
   localparam addr_t addr_mac_da1        = 8'h08;
   localparam addr_t addr_tx_pkt_cnt     = 8'h09;  // read only
   localparam addr_t addr_rnd_seed0      = 8'h0a;
   localparam addr_t addr_rnd_seed1      = 8'h0b;
   localparam addr_t addr_rnd_seed2      = 8'h0c;
   localparam addr_t addr_pkt_length     = 8'h0d;

   localparam len_t hdr_bytes   = 16'd16;    // two header words
   localparam len_t max_payload = 16'd9584;

   localparam int prbs_w    = 23;
   localparam int prbs_tap  = 18;            // x^23 + x^18 + 1
   localparam int seed_w    = 3 * prbs_w;
   localparam int seed_hi_w = seed_w - 64;   // bits kept from seed word 2

   // nonzero so the generators never lock up at all zeros
   localparam word_t                seed0_rst = 32'h5eed_0000;
   localparam word_t                seed1_rst = 32'h5eed_0001;
   localparam logic [seed_hi_w-1:0] seed2_rst = 5'h0d;

   localparam beat_t      incr_first = 64'h0001_0203_0405_0607;
   localparam logic [7:0] incr_step  = 8'd8;  // added to every byte

endpackage

/* hw/pkt_gen_top.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// packet generator top, register bus in, 64-bit stream out
//--------------------------------------------------------------------------
module pkt_gen_top (
   input  logic                reset,        // clock
   input  logic                clk,          // async reset, active high
   input  pkt_gen_pkg::addr_t  address,
   input  logic                write,
   input  logic                read,
   input  pkt_gen_pkg::word_t  writedata,
   output pkt_gen_pkg::word_t  readdata,
   output logic                waitrequest,
   input  logic                tx_ready,
   output pkt_gen_pkg::beat_t  tx_data,
   output logic                tx_valid,
   output logic                tx_sop,
   output logic                tx_eop,
   output pkt_gen_pkg::empty_t tx_empty
);
   import pkt_gen_pkg::*;

   word_t             tx_pkt_cnt;
   logic              start;
   logic              stop;
   word_t             num_pkts;
   logic              random_payload;
   len_t              pkt_length;
   logic [47:0]       mac_sa;
   logic [47:0]       mac_da;
   logic [seed_w-1:0] seed;
   state_t            state;
   len_t              length;
   logic [15:0]       seq_num;
   logic              last_word;
   logic              pkts_done;
   logic [seed_w-1:0] prbs_m;      // all three generators
   beat_t             prbs;

   // PRBS reloads in idle and steps on word 1 and every payload word
   wire prbs_load = (state == st_idle);
   wire prbs_en   = tx_ready && (state == st_src_len_seq || state == st_data);

   assign prbs = prbs_m[63:0];

   pkt_csr         csr_i   (.*);
   pkt_gen_fsm     fsm_i   (.*);
   pkt_len_counter cnt_i   (.*);
   frame_builder   frame_i (.*);

   prbs23 prbs_0 (
      .reset,
      .clk,
      .load   (prbs_load),
      .enable (prbs_en),
      .seed   (seed[prbs_w-1:0]),
      .m      (prbs_m[prbs_w-1:0])
   );

   prbs23 prbs_1 (
      .reset,
      .clk,
      .load   (prbs_load),
      .enable (prbs_en),
      .seed   (seed[2*prbs_w-1:prbs_w]),
      .m      (prbs_m[2*prbs_w-1:prbs_w])
   );

   prbs23 prbs_2 (
      .reset,
      .clk,
      .load   (prbs_load),
      .enable (prbs_en),
      .seed   (seed[3*prbs_w-1:2*prbs_w]),
      .m      (prbs_m[3*prbs_w-1:2*prbs_w])
   );

endmodule

/* hw/pkt_len_counter.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// payload length, byte countdown, sequence number and packet counters
// all update on the same edge as the FSM
//--------------------------------------------------------------------------
module pkt_len_counter (
   input  logic                reset,      // clock
   input  logic                clk,        // async reset
   input  pkt_gen_pkg::state_t state,
   input  logic                tx_ready,
   input  logic                start,
   input  pkt_gen_pkg::len_t   pkt_length,
   input  pkt_gen_pkg::word_t  num_pkts,
   output pkt_gen_pkg::len_t   length,     // payload bytes L
   output logic [15:0]         seq_num,
   output pkt_gen_pkg::word_t  tx_pkt_cnt,
   output logic                last_word,
   output logic                pkts_done
);
   import pkt_gen_pkg::*;

   len_t byte_count;    // payload bytes not yet sent
   len_t len_clamped;

   // header takes 16 bytes, payload capped at max_payload
   always_comb begin
      if (pkt_length < hdr_bytes)                    len_clamped = '0;
      else if (pkt_length > max_payload + hdr_bytes) len_clamped = max_payload;
      else                                           len_clamped = pkt_length - hdr_bytes;
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         length     <= '0;
         byte_count <= '0;
      end else begin
         if (state == st_idle || state == st_transition)
            length <= len_clamped;                  // only between packets
         if (state == st_dest_src && tx_ready)
            byte_count <= length;
         else if (state == st_data && tx_ready)
            byte_count <= byte_count - 16'd8;       // one word gone
      end
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         seq_num    <= '0;
         tx_pkt_cnt <= '0;
      end else if (start) begin
         seq_num    <= '0;
         tx_pkt_cnt <= '0;
      end else begin
         if (state == st_transition) seq_num <= seq_num + 16'd1;
         if (state == st_src_len_seq && tx_ready) tx_pkt_cnt <= tx_pkt_cnt + 32'd1;
      end
   end

   always_comb begin
      case (state)
         st_src_len_seq: last_word = (byte_count == '0);
         st_data:        last_word = (byte_count <= 16'd8);
         default:        last_word = 1'b0;
      endcase
   end

   assign pkts_done = (tx_pkt_cnt >= num_pkts);

   // the FSM leaves data before the count can run out
   a_no_wrap: assert property (@(posedge reset) disable iff (clk)
      state == st_data |-> byte_count != '0);

endmodule

/* hw/prbs23.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// 23-bit PRBS, x^23 + x^18 + 1, advances 23 bits per enable
//--------------------------------------------------------------------------
module prbs23 (
   input  logic                           reset,   // clock
   input  logic                           clk,     // async reset
   input  logic                           load,
   input  logic                           enable,
   input  logic [pkt_gen_pkg::prbs_w-1:0] seed,
   output logic [pkt_gen_pkg::prbs_w-1:0] m
);
   import pkt_gen_pkg::*;

   logic [prbs_w-1:0] m_nxt;

   // unrolled, lsb goes out first
   always_comb begin
      m_nxt = m;
      for (int i = 0; i < prbs_w; i++) begin
         m_nxt = {m_nxt[prbs_tap] ^ m_nxt[0], m_nxt[prbs_w-1:1]};
      end
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk)         m <= '0;
      else if (load)   m <= seed;      // load wins over enable
      else if (enable) m <= m_nxt;
   end

endmodule

/* test/tb_pkt_gen.sv */
`timescale 1ns/1ps
//---------------------------------------------------------------------------
// testbench for the packet generator, configures it over the register bus
// and checks every transferred stream word against a packet layout model
// tx_ready is random in the back-pressure and random payload runs
//---------------------------------------------------------------------------
module tb_pkt_gen;
   import pkt_gen_pkg::*;

   localparam int len_incr  = 37;      // L = 21, three payload words, empty 3
   localparam int len_short = 10;      // L = 0, eop on word 1
   localparam int len_even  = 48;      // L = 32, empty 0
   localparam int len_big   = 12000;   // clamped to max_payload
   localparam int len_bp    = 45;
   localparam int len_rnd   = 40;
   localparam int len_stop  = 64;

   localparam logic [47:0] sa = 48'h0a1b_2c3d_4e5f;
   localparam logic [47:0] da = 48'h1122_3344_5566;

   // payload bytes for a given packet length register value
   function automatic int payload_len(input int plen);
      if (plen < int'(hdr_bytes)) return 0;
      if (plen > int'(max_payload) + int'(hdr_bytes)) return int'(max_payload);
      return plen - int'(hdr_bytes);
   endfunction

   function automatic int pkt_words(input int plen);
      return 2 + (payload_len(plen) + 7) / 8;
   endfunction

   localparam int cycle_limit = 4 * (3 * pkt_words(len_incr) + 2 * pkt_words(len_short)
      + pkt_words(len_even) + pkt_words(len_big) + 4 * pkt_words(len_bp)
      + 4 * pkt_words(len_rnd) + 2 * pkt_words(len_stop)) + 200;

   logic   reset     = 1'b0;   // clock
   logic   clk       = 1'b1;   // async reset, high from time 0
   addr_t  address   = '0;
   logic   write     = 1'b0;
   logic   read      = 1'b0;
   word_t  writedata = '0;
   logic   tx_ready  = 1'b0;
   word_t  readdata;
   logic   waitrequest;
   beat_t  tx_data;
   logic   tx_valid;
   logic   tx_sop;
   logic   tx_eop;
   empty_t tx_empty;

   logic [69:0] exp_q[$];      // {care, sop, eop, empty, data} per word
   beat_t       rand_q[$];     // random payload as transferred
   int          rx_idx       = 0;
   int          sop_cnt      = 0;
   int          cycle_cnt    = 0;
   int          rng_seed     = 32'h29dde069;
   int          rnd;
   bit          ready_random = 1'b0;
   bit          bus_first    = 1'b0;   // first cycle of a bus access

   wire xfer = tx_valid && tx_ready;

   always #20 reset = ~reset;

   pkt_gen_top dut_i (.*);

   //------------------------------------------------------------------------
   // failure reporting
   //------------------------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what);
      abort_run($sformatf("error at %0d ns: %s", $time, what));
   endtask

   // stream inputs change on the falling edge only
   always @(negedge reset) begin
      rnd = $random(rng_seed);
      tx_ready <= ready_random ? rnd[0] : 1'b1;
   end

   always @(posedge reset) begin
      if (!clk && xfer) begin
         if (rx_idx < exp_q.size() && !exp_q[rx_idx][69])
            rand_q.push_back(tx_data);   // random word, kept for the repeat run
         if (tx_sop) sop_cnt <= sop_cnt + 1;
         rx_idx <= rx_idx + 1;
      end
   end

   always @(posedge reset) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
         abort_run($sformatf("run timed out after %0d clock cycles", cycle_cnt));
   end

   //------------------------------------------------------------------------
   // stream and bus checks
   //------------------------------------------------------------------------
   a_in_plan: assert property (@(posedge reset) disable iff (clk)
      xfer |-> rx_idx < exp_q.size())
      else report_mismatch("word transferred after the planned packets");

   a_marks: assert property (@(posedge reset) disable iff (clk)
      xfer |-> {tx_sop, tx_eop, tx_empty} == exp_q[rx_idx][68:64])
      else report_mismatch("sop, eop or empty differs from the model");

   a_data: assert property (@(posedge reset) disable iff (clk)
      xfer && exp_q[rx_idx][69] |-> tx_data == exp_q[rx_idx][63:0])
      else report_mismatch("tx_data differs from the model");

   // high only in the first cycle of an access
   a_wait: assert property (@(posedge reset) disable iff (clk)
      waitrequest == bus_first)
      else report_mismatch("waitrequest out of step with the access");

   //------------------------------------------------------------------------
   // bus and model tasks
   //------------------------------------------------------------------------
   task automatic bus_write(input addr_t addr, input word_t data);
      @(negedge reset);
      address   = addr;
      writedata = data;
      write     = 1'b1;
      bus_first = 1'b1;
      @(negedge reset);
      bus_first = 1'b0;
      while (waitrequest) @(negedge reset);
      @(negedge reset);   // accepted on the edge just passed
      write = 1'b0;
   endtask

   task automatic bus_read(input addr_t addr, output word_t data);
      @(negedge reset);
      address   = addr;
      read      = 1'b1;
      bus_first = 1'b1;
      @(negedge reset);
      bus_first = 1'b0;
      while (waitrequest) @(negedge reset);
      data = readdata;    // one edge after read
      read = 1'b0;
   endtask

   task automatic check_read(input addr_t addr, input word_t exp);
      word_t got;
      bus_read(addr, got);
      assert (got == exp)
         else report_mismatch($sformatf("register %0d reads %h, expected %h", addr, got, exp));
   endtask

   // words of npkts packets as the layout rules give them
   task automatic plan_packets(input int npkts, input int plen, input bit rnd_payload);
      int     l;
      int     nw;
      beat_t  w;
      empty_t last_empty;
      l          = payload_len(plen);
      nw         = (l + 7) / 8;
      last_empty = empty_t'((8 - l % 8) % 8);
      for (int p = 0; p < npkts; p++) begin
         exp_q.push_back({1'b1, 1'b1, 1'b0, 3'd0, da, sa[47:32]});
         exp_q.push_back({1'b1, 1'b0, nw == 0, 3'd0, sa[31:0], l[15:0], p[15:0]});
         for (int i = 0; i < nw; i++) begin
            for (int b = 0; b < 8; b++)
               w[b*8 +: 8] = 8'(7 - b + 8 * i);   // msb byte starts at 00
            exp_q.push_back({!rnd_payload, 1'b0, i == nw - 1,
                             (i == nw - 1) ? last_empty : 3'd0, w});
         end
      end
   endtask

   task automatic wait_drained();
      while (rx_idx < exp_q.size()) @(negedge reset);
   endtask

   task automatic run_packets(input int npkts, input int plen, input bit rnd_payload);
      bus_write(addr_num_pkts, word_t'(npkts));
      bus_write(addr_pkt_length, word_t'(plen));
      bus_write(addr_random_payload, word_t'(rnd_payload));
      plan_packets(npkts, plen, rnd_payload);
      bus_write(addr_start, 32'd1);
      wait_drained();
      @(negedge reset);
      assert (!tx_valid) else report_mismatch("tx_valid still high after the last packet");
      check_read(addr_tx_pkt_cnt, word_t'(npkts));
   endtask

   //------------------------------------------------------------------------
   // test sequence
   //------------------------------------------------------------------------
   initial begin
      addr_t reg_addr [11];
      word_t reg_val  [11];
      int    half;
      int    sop_target;
      reg_addr = '{addr_num_pkts, addr_random_payload, addr_stop, addr_mac_sa0,
                   addr_mac_sa1, addr_mac_da0, addr_mac_da1, addr_rnd_seed0,
                   addr_rnd_seed1, addr_rnd_seed2, addr_pkt_length};
      reg_val  = '{32'h3, 32'h1, 32'h1, 32'h2c3d_4e5f, 32'h0a1b, 32'h3344_5566,
                   32'h1122, 32'h1234_5678, 32'h9abc_def0, 32'h15, 32'h25};
      repeat (2) @(negedge reset);
      clk = 1'b0;

      check_read(addr_tx_pkt_cnt, '0);
      foreach (reg_addr[i])
         bus_write(reg_addr[i], reg_val[i]);
      foreach (reg_addr[i])
         check_read(reg_addr[i], reg_val[i]);
      check_read(8'h01, '0);   // holes in the map
      check_read(8'h0e, '0);
      check_read(8'hff, '0);
      bus_write(addr_stop, '0);

      run_packets(3, len_incr, 1'b0);
      run_packets(2, len_short, 1'b0);
      run_packets(1, len_even, 1'b0);
      run_packets(1, len_big, 1'b0);

      ready_random = 1'b1;   // back-pressure from here
      run_packets(4, len_bp, 1'b0);

      // same seed twice, sequences must match
      rand_q.delete();
      run_packets(2, len_rnd, 1'b1);
      run_packets(2, len_rnd, 1'b1);
      half = rand_q.size() / 2;
      assert (half == 6) else report_mismatch("wrong number of random payload words");
      for (int i = 0; i < half; i++) begin
         assert (rand_q[i] == rand_q[i + half])
            else report_mismatch($sformatf("random word %0d differs between runs", i));
      end
      assert (rand_q[0] != incr_first) else report_mismatch("random payload is incrementing");

      // stop lands inside the second packet
      ready_random = 1'b0;
      bus_write(addr_num_pkts, 32'd10);
      bus_write(addr_pkt_length, word_t'(len_stop));
      bus_write(addr_random_payload, '0);
      plan_packets(2, len_stop, 1'b0);
      sop_target = sop_cnt + 2;
      bus_write(addr_start, 32'd1);
      while (sop_cnt < sop_target) @(negedge reset);
      bus_write(addr_stop, 32'd1);
      wait_drained();
      repeat (20) @(negedge reset);   // any further sop trips a_in_plan
      assert (!tx_valid) else report_mismatch("tx_valid high after stop");
      check_read(addr_tx_pkt_cnt, 32'd2);
      bus_write(addr_stop, '0);

      if (rx_idx != exp_q.size()) begin
         abort_run("not every planned word was transferred");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

/* vlog.f */
hw/pkt_gen_pkg.sv
hw/prbs23.sv
hw/pkt_csr.sv
hw/pkt_gen_fsm.sv
hw/pkt_len_counter.sv
hw/frame_builder.sv
hw/pkt_gen_top.sv
test/tb_pkt_gen.sv
